// ==== core_pkg.sv ====
package core_pkg;

    // Source of the value written back to the register file
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC  = 2'd2,   // Link address pc+4
        WB_CSR = 2'd3
    } wb_sel_e;

    // Register write enable from decode
    typedef enum logic [0:0] {
        REN_X = 1'b0,    // No register write
        REN_S = 1'b1
    } rf_wen_e;

    // Control fields that survive down to write-back
    typedef struct packed {
        wb_sel_e      wb_sel;
        rf_wen_e      rf_wen;
        logic [4:0]   wb_addr;   // Destination register
    } ctrl_t;

    // What the memory stage delivers each cycle
    typedef struct packed {
        logic         valid;
        logic [31:0]  pc;
        logic [31:0]  inst;
        logic [63:0]  inst_id;   // Unique per dynamic instruction
        ctrl_t        ctrl;
        logic [31:0]  alu_out;
        logic [31:0]  mem_rdata;
        logic [31:0]  csr_rdata;
    } wb_bundle_t;

    // Register write request from the write-back stage to the register file
    typedef struct packed {
        logic         en;
        logic [4:0]   addr;
        logic [31:0]  data;
    } rf_write_t;

    // Id held by the replay detector before any instruction arrives
    localparam logic [63:0] INST_ID_NONE = 64'hFFFF_0000_0000_0000;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file import core_pkg::*; #(
    parameter logic [31:0] RF_INIT_VALUE = 32'hFFFF_FFFF,
    parameter logic [31:0] SP_INIT_VALUE = 32'h0000_7500
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  rf_write_t   rf_wr_i,
    input  logic [4:0]  rs1_addr_i,
    input  logic [4:0]  rs2_addr_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o
);

    localparam logic [4:0] SP_ADDR = 5'd2;

    // x0 has no storage
    logic [31:0] regs [1:31];
    logic        wr_active;

    assign wr_active = rf_wr_i.en && (rf_wr_i.addr != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                if (i == int'(SP_ADDR)) begin
                    regs[i] <= SP_INIT_VALUE;
                end else begin
                    regs[i] <= RF_INIT_VALUE;
                end
            end
        end else if (wr_active) begin
            regs[rf_wr_i.addr] <= rf_wr_i.data;
        end
    end

    // One read port with write-through bypass
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        logic [31:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (wr_active && (addr == rf_wr_i.addr)) begin
            value = rf_wr_i.data;   // Retiring result seen by decode
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
    end

    always_comb begin
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the write-back testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_top \
    -f sim.f \
    --Mdir obj_dir \
    -o tb_top_sim

# The simulator may stop early, the log decides the result
./obj_dir/tb_top_sim 2>&1 | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi

// ==== sim.f ====
core_pkg.sv
wb_stage.sv
reg_file.sv
wb_top.sv
wb_properties.sv
tb_top.sv

// ==== tb_top.sv ====
`timescale 1ns/1ps

module tb_top import core_pkg::*; ();

    localparam logic [31:0] EXIT_PC        = 32'h0000_0044;
    localparam logic [31:0] RF_INIT_VALUE  = 32'hFFFF_FFFF;
    localparam logic [31:0] SP_INIT_VALUE  = 32'h0000_7500;
    localparam logic [31:0] RNG_SEED       = 32'd88442;
    localparam int          TIMEOUT_CYCLES = 600;   // About twice the length of all phases

    logic        clk = 1'b0;
    logic        rst_n_i;
    wb_bundle_t  wb_i;
    logic [4:0]  rs1_addr_i;
    logic [4:0]  rs2_addr_i;
    logic [31:0] rs1_data_o;
    logic [31:0] rs2_data_o;
    logic [31:0] wb_wdata_o;
    logic [31:0] retire_count_o;
    logic        exit_o;

    // Reference model state
    logic [31:0] model_regs [0:31];
    logic [31:0] model_count;
    logic        model_exit;
    logic [63:0] model_last_id;

    logic [31:0] rng_state;
    logic [63:0] next_id;
    int          cycle_count = 0;
    logic        verdict_printed = 1'b0;

    wb_top dut_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wb_i           (wb_i),
        .rs1_addr_i     (rs1_addr_i),
        .rs2_addr_i     (rs2_addr_i),
        .rs1_data_o     (rs1_data_o),
        .rs2_data_o     (rs2_data_o),
        .wb_wdata_o     (wb_wdata_o),
        .retire_count_o (retire_count_o),
        .exit_o         (exit_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            stop_with_error("Run did not finish within the cycle limit");
        end
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        verdict_printed = 1'b1;
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
            else stop_with_error($sformatf("ERROR %s expected %08h actual %08h",
                                           name, expected, actual));
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [4:0] random_addr();
        logic [31:0] r;
        r = next_rand();
        return r[4:0];
    endfunction

    // Word aligned and never the exit address by chance
    function automatic logic [31:0] random_pc();
        logic [31:0] pc;
        pc = next_rand() & 32'hFFFF_FFFC;
        if (pc == EXIT_PC) begin
            pc = pc + 32'd8;
        end
        return pc;
    endfunction

    function automatic wb_bundle_t random_bundle();
        logic [31:0] r;
        wb_bundle_t  b;
        r              = next_rand();
        b.valid        = 1'b1;
        b.pc           = random_pc();
        b.inst         = next_rand();
        b.inst_id      = next_id;
        b.ctrl.wb_sel  = wb_sel_e'(r[1:0]);
        b.ctrl.rf_wen  = (r[3:2] != 2'd0) ? REN_S : REN_X;   // Mostly writes
        b.ctrl.wb_addr = r[8:4];
        b.alu_out      = next_rand();
        b.mem_rdata    = next_rand();
        b.csr_rdata    = next_rand();
        next_id        = next_id + 64'd1;
        return b;
    endfunction

    function automatic logic [31:0] expected_wdata(input wb_bundle_t b);
        logic [31:0] value;
        case (b.ctrl.wb_sel)
            WB_ALU:  value = b.alu_out;
            WB_MEM:  value = b.mem_rdata;
            WB_PC:   value = b.pc + 32'd4;
            default: value = b.csr_rdata;
        endcase
        return value;
    endfunction

    function automatic logic [31:0] expected_read(input logic [4:0] addr, input logic wr_en,
                                                  input logic [4:0] wr_addr,
                                                  input logic [31:0] wr_data);
        logic [31:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (wr_en && (addr == wr_addr)) begin
            value = wr_data;   // Same-cycle forward
        end else begin
            value = model_regs[addr];
        end
        return value;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = RF_INIT_VALUE;
        end
        model_regs[0] = '0;
        model_regs[2] = SP_INIT_VALUE;
        model_count   = '0;
        model_exit    = 1'b0;
        model_last_id = INST_ID_NONE;
    endtask

    // Drive one cycle, check before the edge and advance the model past it
    task automatic step(input wb_bundle_t b, input logic [4:0] ra1, input logic [4:0] ra2);
        logic [31:0] exp_wdata;
        logic        is_new;
        logic        wr_en;
        @(posedge clk);
        #1;
        wb_i       = b;
        rs1_addr_i = ra1;
        rs2_addr_i = ra2;
        #7;
        exp_wdata = expected_wdata(b);
        is_new    = b.valid && (b.inst_id != model_last_id);
        wr_en     = is_new && (b.ctrl.rf_wen == REN_S);
        check_value("wb_wdata_o", exp_wdata, wb_wdata_o);
        check_value("rs1_data_o", expected_read(ra1, wr_en, b.ctrl.wb_addr, exp_wdata),
                    rs1_data_o);
        check_value("rs2_data_o", expected_read(ra2, wr_en, b.ctrl.wb_addr, exp_wdata),
                    rs2_data_o);
        check_value("retire_count_o", model_count, retire_count_o);
        check_value("exit_o", {31'd0, model_exit}, {31'd0, exit_o});
        if (wr_en && (b.ctrl.wb_addr != 5'd0)) begin
            model_regs[b.ctrl.wb_addr] = exp_wdata;
        end
        if (b.valid) begin
            model_last_id = b.inst_id;
        end
        if (is_new) begin
            model_count = model_count + 32'd1;
            if (b.pc == EXIT_PC) begin
                model_exit = 1'b1;
            end
        end
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        #1;
        rst_n_i = 1'b0;
        wb_i    = '0;
        repeat (cycles) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        model_reset();
    endtask

    initial begin
        wb_bundle_t  b;
        wb_bundle_t  held;
        logic [31:0] r;
        logic [4:0]  last_dest;
        int          reps;
        rng_state  = RNG_SEED;
        next_id    = 64'd1;
        rst_n_i    = 1'b0;
        wb_i       = '0;
        rs1_addr_i = '0;
        rs2_addr_i = '0;
        model_reset();
        repeat (5) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // Reset values on every address
        for (int i = 0; i < 32; i++) begin
            step('0, 5'(i), 5'(31 - i));
        end

        // All four result sources in turn
        for (int i = 0; i < 48; i++) begin
            b = random_bundle();
            b.ctrl.wb_sel = wb_sel_e'(i[1:0]);
            step(b, random_addr(), random_addr());
        end

        // Port 1 reads the previous destination one cycle later
        last_dest = 5'd0;
        for (int n = 0; n < 100; n++) begin
            b = random_bundle();
            step(b, last_dest, random_addr());
            last_dest = b.ctrl.wb_addr;
        end

        // Replays with idle gaps
        for (int n = 0; n < 12; n++) begin
            b    = random_bundle();
            r    = next_rand();
            reps = 2 + int'(r[1:0]);
            for (int k = 0; k < reps; k++) begin
                step(b, b.ctrl.wb_addr, random_addr());
                if (r[4 + k]) begin
                    held       = b;
                    held.valid = 1'b0;
                    step(held, b.ctrl.wb_addr, random_addr());
                end
            end
        end

        for (int n = 0; n < 12; n++) begin
            b = random_bundle();
            b.ctrl.rf_wen  = REN_S;
            b.ctrl.wb_addr = 5'd0;
            step(b, 5'd0, 5'd0);
        end
        for (int n = 0; n < 12; n++) begin
            b = random_bundle();
            b.ctrl.rf_wen = REN_S;
            step(b, b.ctrl.wb_addr, b.ctrl.wb_addr);
        end

        // Exit address seen first as idle and then as a replay
        b       = random_bundle();
        b.valid = 1'b0;
        b.pc    = EXIT_PC;
        step(b, random_addr(), random_addr());
        b = random_bundle();
        step(b, random_addr(), random_addr());
        b.pc = EXIT_PC;
        step(b, random_addr(), random_addr());
        step(b, random_addr(), random_addr());
        b    = random_bundle();
        b.pc = EXIT_PC;
        step(b, random_addr(), random_addr());
        repeat (6) step(random_bundle(), random_addr(), random_addr());
        check_value("exit_o", 32'd1, {31'd0, exit_o});

        apply_reset(5);
        for (int i = 0; i < 4; i++) begin
            step('0, random_addr(), 5'd2);
        end

        verdict_printed = 1'b1;
        $display("*** PASSED ***");
        $finish;
    end

    // A stop from a failed property lands here without a verdict
    final begin
        if (!verdict_printed) begin
            $display("*** FAILED ***");
        end
    end

endmodule

// ==== wb_properties.sv ====
`timescale 1ns/1ps

module wb_properties import core_pkg::*; (
    input logic        clk,
    input logic        rst_n_i,
    input wb_bundle_t  wb_i,
    input rf_write_t   rf_wr_i,
    input logic [4:0]  rs1_addr_i,
    input logic [4:0]  rs2_addr_i,
    input logic [31:0] rs1_data_i,
    input logic [31:0] rs2_data_i,
    input logic [31:0] retire_count_i,
    input logic        exit_i
);

    logic [63:0] seen_id_q;
    logic        new_id;
    logic        wr_live;

    // Independent tracker of the last valid id
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            seen_id_q <= INST_ID_NONE;
        end else if (wb_i.valid) begin
            seen_id_q <= wb_i.inst_id;
        end
    end

    assign new_id  = wb_i.valid && (wb_i.inst_id != seen_id_q);
    assign wr_live = rf_wr_i.en && (rf_wr_i.addr != 5'd0);

    x0_rs1: assert property (@(posedge clk) (rs1_addr_i == 5'd0) |-> (rs1_data_i == 32'd0))
        else $error("Register 0 read nonzero data on port 1");

    x0_rs2: assert property (@(posedge clk) (rs2_addr_i == 5'd0) |-> (rs2_data_i == 32'd0))
        else $error("Register 0 read nonzero data on port 2");

    exit_sticky: assert property (@(posedge clk) ($past(rst_n_i) && $past(exit_i)) |-> exit_i)
        else $error("Exit flag fell without a reset");

    retire_step: assert property (@(posedge clk)
        ($past(rst_n_i) && $past(new_id)) |-> (retire_count_i == $past(retire_count_i) + 32'd1))
        else $error("Retire count did not advance by one after a new instruction");

    retire_hold: assert property (@(posedge clk)
        ($past(rst_n_i) && !$past(new_id)) |-> $stable(retire_count_i))
        else $error("Retire count moved without a new instruction");

    bypass_rs1: assert property (@(posedge clk)
        (wr_live && (rs1_addr_i == rf_wr_i.addr)) |-> (rs1_data_i == rf_wr_i.data))
        else $error("Port 1 missed the write in progress");

    bypass_rs2: assert property (@(posedge clk)
        (wr_live && (rs2_addr_i == rf_wr_i.addr)) |-> (rs2_data_i == rf_wr_i.data))
        else $error("Port 2 missed the write in progress");

endmodule

bind wb_top wb_properties props_i (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .wb_i           (wb_i),
    .rf_wr_i        (rf_wr),
    .rs1_addr_i     (rs1_addr_i),
    .rs2_addr_i     (rs2_addr_i),
    .rs1_data_i     (rs1_data_o),
    .rs2_data_i     (rs2_data_o),
    .retire_count_i (retire_count_o),
    .exit_i         (exit_o)
);

// ==== wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage import core_pkg::*; #(
    parameter logic [31:0] EXIT_PC = 32'h0000_0044
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  wb_bundle_t  wb_i,
    output rf_write_t   rf_wr_o,
    output logic [31:0] wb_wdata_o,
    output logic [31:0] retire_count_o,
    output logic        exit_o
);

    logic [31:0] wb_data;
    logic [31:0] link_addr;
    logic [63:0] last_id_q;
    logic        is_new;
    logic        hit_exit;
    logic [31:0] retire_count_q;
    logic        exit_q;

    assign link_addr = wb_i.pc + 32'd4;

    // Result select does not depend on valid
    always_comb begin
        case (wb_i.ctrl.wb_sel)
            WB_MEM:  wb_data = wb_i.mem_rdata;
            WB_PC:   wb_data = link_addr;
            WB_CSR:  wb_data = wb_i.csr_rdata;
            default: wb_data = wb_i.alu_out;
        endcase
    end

    assign wb_wdata_o = wb_data;

    // A stalled instruction shows up again with the same id
    assign is_new = wb_i.valid && (wb_i.inst_id != last_id_q);

    assign hit_exit = is_new && (wb_i.pc == EXIT_PC);

    // Address 0 is filtered inside the register file
    always_comb begin
        rf_wr_o.en   = is_new && (wb_i.ctrl.rf_wen == REN_S);
        rf_wr_o.addr = wb_i.ctrl.wb_addr;
        rf_wr_o.data = wb_data;
    end

    // Replay detector stores every valid id
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            last_id_q <= INST_ID_NONE;
        end else if (wb_i.valid) begin
            last_id_q <= wb_i.inst_id;
        end
    end

    // Retired instruction counter
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_count_q <= '0;
        end else if (is_new) begin
            retire_count_q <= retire_count_q + 32'd1;
        end
    end

    // Sticky exit flag
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            exit_q <= 1'b0;
        end else if (hit_exit) begin
            exit_q <= 1'b1;   // Held until the next reset
        end
    end

    assign retire_count_o = retire_count_q;
    assign exit_o         = exit_q;

endmodule

// ==== wb_top.sv ====
`timescale 1ns/1ps

module wb_top import core_pkg::*; #(
    parameter logic [31:0] EXIT_PC       = 32'h0000_0044,
    parameter logic [31:0] RF_INIT_VALUE = 32'hFFFF_FFFF,
    parameter logic [31:0] SP_INIT_VALUE = 32'h0000_7500
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  wb_bundle_t  wb_i,
    input  logic [4:0]  rs1_addr_i,
    input  logic [4:0]  rs2_addr_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o,
    output logic [31:0] wb_wdata_o,
    output logic [31:0] retire_count_o,
    output logic        exit_o
);

    // Write request from the stage into the register file
    rf_write_t rf_wr;

    wb_stage #(
        .EXIT_PC        (EXIT_PC)
    ) wb_stage_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wb_i           (wb_i),
        .rf_wr_o        (rf_wr),
        .wb_wdata_o     (wb_wdata_o),
        .retire_count_o (retire_count_o),
        .exit_o         (exit_o)
    );

    reg_file #(
        .RF_INIT_VALUE  (RF_INIT_VALUE),
        .SP_INIT_VALUE  (SP_INIT_VALUE)
    ) reg_file_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rf_wr_i        (rf_wr),
        .rs1_addr_i     (rs1_addr_i),
        .rs2_addr_i     (rs2_addr_i),
        .rs1_data_o     (rs1_data_o),
        .rs2_data_o     (rs2_data_o)
    );

endmodule
